//--- source/fb_defs.svh
`ifndef FB_DEFS_SVH
`define FB_DEFS_SVH

// one color channel of a pixel
`define FB_COLOR_WIDTH 4

// raster counters and the visible frame size
`define FB_H_WIDTH 12
`define FB_V_WIDTH 12

// AXI read port, byte addressed
`define FB_ADDR_WIDTH 13
`define FB_DATA_WIDTH 16

// frame buffer size in 16-bit words, which bounds h_visible * v_visible
`define FB_MEM_DEPTH 4096

`endif

//--- source/fb_pkg.sv
`include "fb_defs.svh"
`default_nettype none

package fb_pkg;

  // a pixel sits in the low bits of a memory word, red on top
  typedef struct packed {
    logic [`FB_COLOR_WIDTH-1:0] red;
    logic [`FB_COLOR_WIDTH-1:0] grn;
    logic [`FB_COLOR_WIDTH-1:0] blu;
  } pixel_t;

  typedef enum logic [1:0] {
    BURST_FIXED = 2'b00,
    BURST_INCR  = 2'b01,
    BURST_WRAP  = 2'b10
  } axi_burst_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'b00,
    RESP_EXOKAY = 2'b01,
    RESP_SLVERR = 2'b10,
    RESP_DECERR = 2'b11
  } axi_resp_e;

  typedef enum logic {
    MEM_IDLE = 1'b0,
    MEM_RESP = 1'b1
  } mem_state_e;

endpackage

`default_nettype wire

//--- source/fb_pix.sv
`timescale 1ns/1ps
`include "fb_defs.svh"
`default_nettype none

module fb_pix (
  input  logic                          clk,
  input  logic                          rst_n,

  input  logic [`FB_H_WIDTH-1:0]        h_visible,
  input  logic [`FB_V_WIDTH-1:0]        v_visible,

  output logic                          axi_arvalid,
  output logic [`FB_ADDR_WIDTH-1:0]     axi_araddr,
  output logic [7:0]                    axi_arlen,
  output logic [2:0]                    axi_arsize,
  output fb_pkg::axi_burst_e            axi_arburst,
  input  logic                          axi_arready,
  input  logic                          axi_rvalid,
  input  logic [`FB_DATA_WIDTH-1:0]     axi_rdata,
  input  fb_pkg::axi_resp_e             axi_rresp,
  input  logic                          axi_rlast,
  output logic                          axi_rready,

  output logic                          pix_valid,
  output logic [`FB_COLOR_WIDTH-1:0]    pix_red,
  output logic [`FB_COLOR_WIDTH-1:0]    pix_grn,
  output logic [`FB_COLOR_WIDTH-1:0]    pix_blu,
  output logic                          pix_eol,
  output logic                          pix_eof,
  input  logic                          pix_ready
);
  import fb_pkg::*;

  localparam int PIXEL_WIDTH = $bits(pixel_t);

  logic [`FB_H_WIDTH-1:0]    req_x;
  logic [`FB_V_WIDTH-1:0]    req_y;
  logic [`FB_H_WIDTH-1:0]    rsp_x;
  logic [`FB_V_WIDTH-1:0]    rsp_y;
  logic                      req_last_x;
  logic                      req_last_y;
  logic                      rsp_last_x;
  logic                      rsp_last_y;
  logic                      ar_fire;
  logic                      pix_fire;
  pixel_t                    pixel;
  // error responses are never produced and every burst is one beat,
  // so rresp, rlast and the spare data bits carry nothing for us
  logic                      unused_rsp;

  // every request is a single INCR beat of one full data word
  assign axi_arlen   = 8'd0;
  assign axi_arsize  = 3'($clog2(`FB_DATA_WIDTH / 8));
  assign axi_arburst = BURST_INCR;

  // the read data channel is the pixel stream itself
  assign pixel       = pixel_t'(axi_rdata[PIXEL_WIDTH-1:0]);
  assign pix_valid   = axi_rvalid;
  assign axi_rready  = pix_ready;
  assign pix_red     = pixel.red;
  assign pix_grn     = pixel.grn;
  assign pix_blu     = pixel.blu;

  assign unused_rsp  = &{1'b0, axi_rresp, axi_rlast, axi_rdata[`FB_DATA_WIDTH-1:PIXEL_WIDTH]};

  assign ar_fire     = axi_arvalid && axi_arready;
  assign pix_fire    = pix_valid && pix_ready;

  assign req_last_x  = (req_x == h_visible - 1'b1);
  assign req_last_y  = (req_y == v_visible - 1'b1);
  assign rsp_last_x  = (rsp_x == h_visible - 1'b1);
  assign rsp_last_y  = (rsp_y == v_visible - 1'b1);

  // markers come from where the response counter stands
  assign pix_eol     = rsp_last_x;
  assign pix_eof     = rsp_last_x && rsp_last_y;

  // the request side walks the raster and the byte address together
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      axi_arvalid <= 1'b0;
      axi_araddr  <= '0;
      req_x       <= '0;
      req_y       <= '0;
    end else begin
      // raised once out of reset and never dropped since there is always more frame
      axi_arvalid <= 1'b1;
      if (ar_fire) begin
        if (req_last_x) begin
          req_x <= '0;
          if (req_last_y) begin
            req_y      <= '0;
            axi_araddr <= '0;
          end else begin
            req_y      <= req_y + 1'b1;
            axi_araddr <= axi_araddr + (`FB_ADDR_WIDTH'(1) << axi_arsize);
          end
        end else begin
          req_x      <= req_x + 1'b1;
          axi_araddr <= axi_araddr + (`FB_ADDR_WIDTH'(1) << axi_arsize);
        end
      end
    end
  end

  // the response side counts accepted pixels so the markers track the data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp_x <= '0;
      rsp_y <= '0;
    end else if (pix_fire) begin
      if (rsp_last_x) begin
        rsp_x <= '0;
        rsp_y <= rsp_last_y ? '0 : rsp_y + 1'b1;
      end else begin
        rsp_x <= rsp_x + 1'b1;
      end
    end
  end

  // a pending request keeps its address until the memory takes it
  ar_hold : assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid && !axi_arready |=> axi_arvalid && $stable(axi_araddr));

  // the memory must keep a pixel on offer until the consumer takes it
  pix_hold : assert property (@(posedge clk) disable iff (!rst_n)
    pix_valid && !pix_ready |=> pix_valid && $stable({pix_red, pix_grn, pix_blu}));

endmodule

`default_nettype wire

//--- source/fb_mem.sv
`timescale 1ns/1ps
`include "fb_defs.svh"
`default_nettype none

module fb_mem (
  input  logic                               clk,
  input  logic                               rst_n,

  input  logic                               mem_wr_en,
  input  logic [$clog2(`FB_MEM_DEPTH)-1:0]   mem_wr_addr,
  input  logic [`FB_DATA_WIDTH-1:0]          mem_wr_data,

  input  logic                               axi_arvalid,
  input  logic [`FB_ADDR_WIDTH-1:0]          axi_araddr,
  input  logic [7:0]                         axi_arlen,
  input  logic [2:0]                         axi_arsize,
  input  fb_pkg::axi_burst_e                 axi_arburst,
  output logic                               axi_arready,
  output logic                               axi_rvalid,
  output logic [`FB_DATA_WIDTH-1:0]          axi_rdata,
  output fb_pkg::axi_resp_e                  axi_rresp,
  output logic                               axi_rlast,
  input  logic                               axi_rready
);
  import fb_pkg::*;

  localparam int WORD_AW    = $clog2(`FB_MEM_DEPTH);
  localparam int BYTE_SHIFT = $clog2(`FB_DATA_WIDTH / 8);

  logic [`FB_DATA_WIDTH-1:0] mem [`FB_MEM_DEPTH];
  mem_state_e                state;
  mem_state_e                state_next;
  logic [WORD_AW-1:0]        rd_index;
  logic                      ar_fire;
  logic                      r_fire;
  // the byte offset within a word is always zero for aligned full-word reads
  logic                      unused_offset;

  assign rd_index      = axi_araddr[BYTE_SHIFT +: WORD_AW];
  assign unused_offset = &{1'b0, axi_araddr[BYTE_SHIFT-1:0]};

  assign axi_arready   = (state == MEM_IDLE);
  assign axi_rvalid    = (state == MEM_RESP);
  assign axi_rresp     = RESP_OKAY;
  assign axi_rlast     = 1'b1;

  assign ar_fire       = axi_arvalid && axi_arready;
  assign r_fire        = axi_rvalid && axi_rready;

  // load port
  always_ff @(posedge clk) begin
    if (mem_wr_en) begin
      mem[mem_wr_addr] <= mem_wr_data;
    end
  end

  // the word is captured at the handshake and held for the whole response
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      axi_rdata <= mem[rd_index];
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      MEM_IDLE: begin
        if (ar_fire) begin
          state_next = MEM_RESP;
        end
      end
      MEM_RESP: begin
        // one idle cycle follows every beat so the peak rate is half the clock
        if (r_fire) begin
          state_next = MEM_IDLE;
        end
      end
      default: state_next = MEM_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= MEM_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // only single full-width INCR beats are served
  ar_single_beat : assert property (@(posedge clk) disable iff (!rst_n)
    axi_arvalid |-> axi_arlen == 8'd0 && axi_arburst == BURST_INCR
                    && axi_arsize == 3'(BYTE_SHIFT));

  rdata_hold : assert property (@(posedge clk) disable iff (!rst_n)
    axi_rvalid && !axi_rready |=> axi_rvalid && $stable(axi_rdata));

endmodule

`default_nettype wire

//--- source/fb_pix_top.sv
`timescale 1ns/1ps
`include "fb_defs.svh"
`default_nettype none

module fb_pix_top (
  input  logic                               clk,
  input  logic                               rst_n,

  input  logic [`FB_H_WIDTH-1:0]             h_visible,
  input  logic [`FB_V_WIDTH-1:0]             v_visible,

  input  logic                               mem_wr_en,
  input  logic [$clog2(`FB_MEM_DEPTH)-1:0]   mem_wr_addr,
  input  logic [`FB_DATA_WIDTH-1:0]          mem_wr_data,

  output logic                               pix_valid,
  output logic [`FB_COLOR_WIDTH-1:0]         pix_red,
  output logic [`FB_COLOR_WIDTH-1:0]         pix_grn,
  output logic [`FB_COLOR_WIDTH-1:0]         pix_blu,
  output logic                               pix_eol,
  output logic                               pix_eof,
  input  logic                               pix_ready
);
  import fb_pkg::*;

  // AXI read channel between the reader and the frame buffer
  logic                      axi_arvalid;
  logic [`FB_ADDR_WIDTH-1:0] axi_araddr;
  logic [7:0]                axi_arlen;
  logic [2:0]                axi_arsize;
  axi_burst_e                axi_arburst;
  logic                      axi_arready;
  logic                      axi_rvalid;
  logic [`FB_DATA_WIDTH-1:0] axi_rdata;
  axi_resp_e                 axi_rresp;
  logic                      axi_rlast;
  logic                      axi_rready;

  fb_pix u_pix (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_visible   (h_visible),
    .v_visible   (v_visible),
    .axi_arvalid (axi_arvalid),
    .axi_araddr  (axi_araddr),
    .axi_arlen   (axi_arlen),
    .axi_arsize  (axi_arsize),
    .axi_arburst (axi_arburst),
    .axi_arready (axi_arready),
    .axi_rvalid  (axi_rvalid),
    .axi_rdata   (axi_rdata),
    .axi_rresp   (axi_rresp),
    .axi_rlast   (axi_rlast),
    .axi_rready  (axi_rready),
    .pix_valid   (pix_valid),
    .pix_red     (pix_red),
    .pix_grn     (pix_grn),
    .pix_blu     (pix_blu),
    .pix_eol     (pix_eol),
    .pix_eof     (pix_eof),
    .pix_ready   (pix_ready)
  );

  fb_mem u_mem (
    .clk         (clk),
    .rst_n       (rst_n),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .axi_arvalid (axi_arvalid),
    .axi_araddr  (axi_araddr),
    .axi_arlen   (axi_arlen),
    .axi_arsize  (axi_arsize),
    .axi_arburst (axi_arburst),
    .axi_arready (axi_arready),
    .axi_rvalid  (axi_rvalid),
    .axi_rdata   (axi_rdata),
    .axi_rresp   (axi_rresp),
    .axi_rlast   (axi_rlast),
    .axi_rready  (axi_rready)
  );

endmodule

`default_nettype wire

//--- verif/fb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module fb_clk_gen #(
  parameter int HALF_PERIOD  = 2,
  parameter int RESET_CYCLES = 4
) (
  input  logic hold,
  output logic clk,
  output logic rst_n
);
  logic rst_q = 1'b0;
  int   count = 0;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // reset stays low while held and for RESET_CYCLES edges after the hold drops
  always @(posedge clk) begin
    if (hold) begin
      count <= 0;
      rst_q <= 1'b0;
    end else if (count < RESET_CYCLES - 1) begin
      count <= count + 1;
    end else begin
      rst_q <= 1'b1;
    end
  end

  assign rst_n = rst_q;

endmodule

`default_nettype wire

//--- verif/fb_pix_tb.sv
`timescale 1ns/1ps
`include "fb_defs.svh"
`default_nettype none

module fb_pix_tb;

  localparam int NUM_TESTS     = 8;
  localparam int WORD_AW       = $clog2(`FB_MEM_DEPTH);
  localparam int CW            = `FB_COLOR_WIDTH;
  localparam int DRIVE_DELAY   = 1;
  localparam int PIXEL_TIMEOUT = 100;
  localparam int RESET_TIMEOUT = 20;

  logic                        clk;
  logic                        rst_n;
  logic                        hold;
  logic [`FB_H_WIDTH-1:0]      h_visible;
  logic [`FB_V_WIDTH-1:0]      v_visible;
  logic                        mem_wr_en;
  logic [WORD_AW-1:0]          mem_wr_addr;
  logic [`FB_DATA_WIDTH-1:0]   mem_wr_data;
  logic                        pix_valid;
  logic [CW-1:0]               pix_red;
  logic [CW-1:0]               pix_grn;
  logic [CW-1:0]               pix_blu;
  logic                        pix_eol;
  logic                        pix_eof;
  logic                        pix_ready;

  // what the memory should hold, written alongside the load port
  logic [`FB_DATA_WIDTH-1:0]   mem_copy [`FB_MEM_DEPTH];
  logic [31:0]                 lcg_state;
  string                       cur_test;

  string test_name   [NUM_TESTS];
  int    test_h      [NUM_TESTS];
  int    test_v      [NUM_TESTS];
  int    test_frames [NUM_TESTS];
  bit    test_bp     [NUM_TESTS];

  fb_clk_gen #(.HALF_PERIOD(2), .RESET_CYCLES(4)) u_clk_gen (
    .hold  (hold),
    .clk   (clk),
    .rst_n (rst_n)
  );

  fb_pix_top UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .h_visible   (h_visible),
    .v_visible   (v_visible),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_data (mem_wr_data),
    .pix_valid   (pix_valid),
    .pix_red     (pix_red),
    .pix_grn     (pix_grn),
    .pix_blu     (pix_blu),
    .pix_eol     (pix_eol),
    .pix_eof     (pix_eof),
    .pix_ready   (pix_ready)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_value(input string label, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("CHECK FAILED %s %s: expected 0x%0h, actual 0x%0h",
                         cur_test, label, expected, actual));
    end
  endtask

  task automatic set_entry(input int idx, input string name, input int h, input int v,
                           input int frames, input bit bp);
    test_name[idx]   = name;
    test_h[idx]      = h;
    test_v[idx]      = v;
    test_frames[idx] = frames;
    test_bp[idx]     = bp;
  endtask

  // name, width, height, frames to check, random back-pressure
  task automatic fill_table();
    set_entry(0, "single_1x1",     1,   1,  4, 1'b0);
    set_entry(1, "row_16x1",       16,  1,  3, 1'b0);
    set_entry(2, "column_1x16",    1,   16, 3, 1'b0);
    set_entry(3, "small_8x6",      8,   6,  2, 1'b0);
    set_entry(4, "bp_1x1",         1,   1,  6, 1'b1);
    set_entry(5, "bp_13x7",        13,  7,  3, 1'b1);
    set_entry(6, "full_64x64",     64,  64, 2, 1'b0);
    set_entry(7, "bp_full_128x32", 128, 32, 2, 1'b1);
  endtask

  // holds the DUT in reset, loads a fresh image and lets reset go
  task automatic reset_and_load(input int t);
    int total;
    int waited;
    total     = test_h[t] * test_v[t];
    hold      = 1'b1;
    pix_ready = 1'b0;
    waited    = 0;
    while (rst_n) begin
      @(posedge clk);
      #DRIVE_DELAY;
      waited++;
      if (waited > RESET_TIMEOUT) begin
        fail_run("reset was never asserted by the clock generator");
      end
    end
    // one more edge so the DUT has seen reset low
    @(posedge clk);
    #DRIVE_DELAY;
    h_visible = `FB_H_WIDTH'(test_h[t]);
    v_visible = `FB_V_WIDTH'(test_v[t]);
    for (int i = 0; i < total; i++) begin
      lcg_state   = lcg_next(lcg_state);
      mem_copy[i] = `FB_DATA_WIDTH'(lcg_state[31:16]);
      mem_wr_en   = 1'b1;
      mem_wr_addr = WORD_AW'(i);
      mem_wr_data = `FB_DATA_WIDTH'(lcg_state[31:16]);
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("pix_valid in reset", 32'd0, 32'(pix_valid));
    end
    mem_wr_en = 1'b0;
    hold      = 1'b0;
    waited    = 0;
    while (!rst_n) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("pix_valid around reset release", 32'd0, 32'(pix_valid));
      waited++;
      if (waited > RESET_TIMEOUT) begin
        fail_run("reset was never released by the clock generator");
      end
    end
    // the first cycle in which the DUT runs out of reset still has no pixel
    @(posedge clk);
    #DRIVE_DELAY;
    check_value("pix_valid on the first cycle after reset", 32'd0, 32'(pix_valid));
  endtask

  // returns on the cycle where a pixel is offered and accepted
  task automatic wait_pixel(input bit use_bp);
    int waited;
    waited = 0;
    do begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (use_bp) begin
        lcg_state = lcg_next(lcg_state);
        pix_ready = lcg_state[20];
      end else begin
        pix_ready = 1'b1;
      end
      waited++;
      if (waited > PIXEL_TIMEOUT) begin
        fail_run($sformatf("timeout in %s: no pixel accepted within %0d cycles",
                           cur_test, PIXEL_TIMEOUT));
      end
    end while (!(pix_valid && pix_ready));
  endtask

  // pixel n of a frame is word n with red in the top color field
  task automatic check_pixel(input int f, input int n, input int h, input int total);
    logic [`FB_DATA_WIDTH-1:0] word;
    string                     where;
    int                        x;
    word  = mem_copy[n];
    x     = n % h;
    where = $sformatf("frame %0d pixel %0d", f, n);
    check_value({where, " red"}, 32'(word[3*CW-1 -: CW]), 32'(pix_red));
    check_value({where, " green"}, 32'(word[2*CW-1 -: CW]), 32'(pix_grn));
    check_value({where, " blue"}, 32'(word[CW-1:0]), 32'(pix_blu));
    check_value({where, " eol"}, 32'(x == h - 1), 32'(pix_eol));
    check_value({where, " eof"}, 32'(n == total - 1), 32'(pix_eof));
  endtask

  initial begin
    int total;
    hold        = 1'b1;
    h_visible   = `FB_H_WIDTH'(1);
    v_visible   = `FB_V_WIDTH'(1);
    mem_wr_en   = 1'b0;
    mem_wr_addr = '0;
    mem_wr_data = '0;
    pix_ready   = 1'b0;
    lcg_state   = 32'h2db9d1d1;
    cur_test    = "";
    fill_table();
    for (int t = 0; t < NUM_TESTS; t++) begin
      cur_test = test_name[t];
      total    = test_h[t] * test_v[t];
      reset_and_load(t);
      // several frames in a row also cover the wrap back to word 0
      for (int f = 0; f < test_frames[t]; f++) begin
        for (int n = 0; n < total; n++) begin
          wait_pixel(test_bp[t]);
          check_pixel(f, n, test_h[t], total);
        end
      end
      $display("%s: %0d frames of %0dx%0d pixels checked",
               cur_test, test_frames[t], test_h[t], test_v[t]);
    end
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+source
source/fb_pkg.sv
source/fb_pix.sv
source/fb_mem.sv
source/fb_pix_top.sv
verif/fb_clk_gen.sv
verif/fb_pix_tb.sv

//--- Makefile
TOP = fb_pix_tb

.PHONY: all run lint clean

all: run

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f $(wildcard source/*.sv source/*.svh verif/*.sv)
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
